// File: logic/cache_defs.svh
// Blocking data cache geometry
// Sizes and address field widths shared by every block

`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Capacity and line geometry
`define CACHE_SIZE_BYTES 256
`define CACHE_LINE_BITS  128
`define CACHE_NLINES     16

// Address split: tag | index | byte offset
`define CACHE_IDX_BITS   4
`define CACHE_OFF_BITS   4
`define CACHE_TAG_BITS   24

// Processor and memory side widths
`define CACHE_ADDR_BITS  32
`define CACHE_WORD_BITS  32
`define CACHE_OPQ_BITS   8

`endif

// File: logic/mem_msg_pkg.sv
// Memory message package
// Request and response formats for both cache ports, plus tag entry

`include "cache_defs.svh"

package mem_msg_pkg;

  // Message type codes
  typedef enum logic [2:0] {
    MEM_READ  = 3'd0,
    MEM_WRITE = 3'd1
  } mem_type_e;

  // Processor side request, 77 bits
  typedef struct packed {
    mem_type_e                   type_;
    logic [`CACHE_OPQ_BITS-1:0]  opaque;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [1:0]                  len;
    logic [`CACHE_WORD_BITS-1:0] data;
  } cache_req_t;

  // Processor side response, 45 bits
  typedef struct packed {
    mem_type_e                   type_;
    logic [`CACHE_OPQ_BITS-1:0]  opaque;
    logic [1:0]                  len;
    logic [`CACHE_WORD_BITS-1:0] data;
  } cache_resp_t;

  // Memory side request, 175 bits
  typedef struct packed {
    mem_type_e                   type_;
    logic [`CACHE_OPQ_BITS-1:0]  opaque;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [3:0]                  len;
    logic [`CACHE_LINE_BITS-1:0] data;
  } mem_req_t;

  // Memory side response, 143 bits
  typedef struct packed {
    mem_type_e                   type_;
    logic [`CACHE_OPQ_BITS-1:0]  opaque;
    logic [3:0]                  len;
    logic [`CACHE_LINE_BITS-1:0] data;
  } mem_resp_t;

  // Tag store entry
  typedef struct packed {
    logic                       valid;
    logic [`CACHE_TAG_BITS-1:0] tag;
  } tag_entry_t;

  typedef logic [`CACHE_LINE_BITS-1:0] line_t;

endpackage

// File: logic/line_store_if.sv
// Line store port bundle
// One combinational read port and one synchronous write port

`include "cache_defs.svh"

interface line_store_if #(
  parameter type entry_t  = logic,
  parameter int  IDX_BITS = `CACHE_IDX_BITS
);

  // Read port, data follows index in the same cycle
  logic [IDX_BITS-1:0] rd_idx;
  entry_t              rd_data;

  // Write port, lands on the next rising edge
  logic                wr_en;
  logic [IDX_BITS-1:0] wr_idx;
  entry_t              wr_data;

  // Cache controller side
  modport ctrl (
    output rd_idx, wr_en, wr_idx, wr_data,
    input  rd_data
  );

  // Storage side
  modport store (
    input  rd_idx, wr_en, wr_idx, wr_data,
    output rd_data
  );

endinterface

// File: logic/line_store.sv
// Indexed entry store
// Zero-cycle read, one-cycle write, all entries cleared on reset

`include "cache_defs.svh"

module line_store #(
  parameter type entry_t  = logic,
  parameter int  NENTRIES = `CACHE_NLINES
) (
  input  logic         clk,
  input  logic         arst_n,
  line_store_if.store  port
);

  // --------------------------------------------------------------------------
  // Storage array
  // --------------------------------------------------------------------------

  entry_t mem [NENTRIES];

  // Read is a plain mux on the index
  assign port.rd_data = mem[port.rd_idx];

  // Reset zeroes every entry
  // For the tag store this drops all valid bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NENTRIES; i++) begin
        mem[i] <= '0;
      end
    end else if (port.wr_en) begin
      mem[port.wr_idx] <= port.wr_data;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Controller never writes past the array or through an unknown index
  a_wr_idx_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    port.wr_en |-> (!$isunknown(port.wr_idx) && (int'(port.wr_idx) < NENTRIES))
  );

endmodule

// File: logic/cache_ctrl.sv
// Blocking cache controller
// Hit detect, line refill on read miss, write-through with no allocate

`include "cache_defs.svh"

module cache_ctrl (
  input  logic                     clk,
  input  logic                     arst_n,
  input  mem_msg_pkg::cache_req_t  req,
  input  logic                     req_val,
  output logic                     req_rdy,
  output mem_msg_pkg::cache_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output mem_msg_pkg::mem_req_t    mreq,
  output logic                     mreq_val,
  input  logic                     mreq_rdy,
  input  mem_msg_pkg::mem_resp_t   mresp,
  input  logic                     mresp_val,
  output logic                     mresp_rdy,
  line_store_if.ctrl               tag_if,
  line_store_if.ctrl               data_if
);

  import mem_msg_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_REFILL_REQ, S_REFILL_WAIT, S_WT_REQ, S_WT_WAIT, S_RESP
  } state_e;

  state_e                      state;
  state_e                      state_nxt;
  cache_req_t                  req_r;
  logic [`CACHE_TAG_BITS-1:0]  req_tag;
  logic [`CACHE_IDX_BITS-1:0]  req_idx;
  logic [1:0]                  req_word;
  logic                        is_read;
  logic                        hit;
  logic                        refill_fire;
  logic [`CACHE_WORD_BITS-1:0] word_sel;
  line_t                       merged_line;
  logic                        mreq_pending;

  // --------------------------------------------------------------------------
  // Request register and address split
  // --------------------------------------------------------------------------

  // Captured on acceptance, held for the whole transaction
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      req_r <= req;
    end
  end

  assign req_tag  = req_r.addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
  assign req_idx  = req_r.addr[`CACHE_OFF_BITS +: `CACHE_IDX_BITS];
  assign req_word = req_r.addr[`CACHE_OFF_BITS-1:2];
  assign is_read  = (req_r.type_ == MEM_READ);

  // Both stores looked up at the same index
  assign tag_if.rd_idx  = req_idx;
  assign data_if.rd_idx = req_idx;
  assign tag_if.wr_idx  = req_idx;
  assign data_if.wr_idx = req_idx;

  assign hit      = tag_if.rd_data.valid && (tag_if.rd_data.tag == req_tag);
  assign word_sel = data_if.rd_data[req_word*32 +: 32];

  // Store word spliced into the cached line
  always_comb begin
    merged_line = data_if.rd_data;
    merged_line[req_word*32 +: 32] = req_r.data;
  end

  // --------------------------------------------------------------------------
  // Store updates
  // --------------------------------------------------------------------------

  assign refill_fire = (state == S_REFILL_WAIT) && mresp_val;

  // Tag only changes on refill
  assign tag_if.wr_en   = refill_fire;
  assign tag_if.wr_data = '{valid: 1'b1, tag: req_tag};

  // Data on refill, or on a write that hits
  assign data_if.wr_en   = refill_fire || ((state == S_LOOKUP) && !is_read && hit);
  assign data_if.wr_data = refill_fire ? mresp.data : merged_line;

  // --------------------------------------------------------------------------
  // Handshakes and messages
  // --------------------------------------------------------------------------

  assign req_rdy   = (state == S_IDLE);
  assign mresp_rdy = (state == S_REFILL_WAIT) || (state == S_WT_WAIT);

  // Read hit answers straight out of lookup
  assign resp_val = (state == S_RESP) || ((state == S_LOOKUP) && is_read && hit);

  // Line is already in the data store by S_RESP, so same word path
  assign resp.type_  = req_r.type_;
  assign resp.opaque = req_r.opaque;
  assign resp.len    = 2'd0;
  assign resp.data   = is_read ? word_sel : '0;

  assign mreq_val = (state == S_REFILL_REQ) || (state == S_WT_REQ);

  // Line read at aligned address, or word write in low bits
  assign mreq.type_  = is_read ? MEM_READ : MEM_WRITE;
  assign mreq.opaque = req_r.opaque;
  assign mreq.addr   = is_read ? {req_r.addr[`CACHE_ADDR_BITS-1:`CACHE_OFF_BITS],
                                  {`CACHE_OFF_BITS{1'b0}}}
                               : req_r.addr;
  assign mreq.len    = is_read ? 4'd0 : 4'd4;
  assign mreq.data   = is_read ? '0
                               : {{(`CACHE_LINE_BITS-`CACHE_WORD_BITS){1'b0}}, req_r.data};

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:        if (req_val) state_nxt = S_LOOKUP;
      S_LOOKUP: begin
        if (!is_read) state_nxt = S_WT_REQ;
        else if (!hit) state_nxt = S_REFILL_REQ;
        else if (resp_rdy) state_nxt = S_IDLE;
        else state_nxt = S_RESP;
      end
      S_REFILL_REQ:  if (mreq_rdy) state_nxt = S_REFILL_WAIT;
      S_REFILL_WAIT: if (mresp_val) state_nxt = S_RESP;
      S_WT_REQ:      if (mreq_rdy) state_nxt = S_WT_WAIT;
      S_WT_WAIT:     if (mresp_val) state_nxt = S_RESP;
      S_RESP:        if (resp_rdy) state_nxt = S_IDLE;
      default:       state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Memory request in flight, cleared by its response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mreq_pending <= 1'b0;
    end else if (mreq_val && mreq_rdy) begin
      mreq_pending <= 1'b1;
    end else if (mresp_val && mresp_rdy) begin
      mreq_pending <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Stalled response stays up and unchanged
  a_resp_hold: assert property (
    @(posedge clk) disable iff (!arst_n)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp))
  );

  // No second memory request before the first one returns
  a_one_outstanding: assert property (
    @(posedge clk) disable iff (!arst_n)
    mreq_val |-> !mreq_pending
  );

endmodule

// File: logic/blocking_cache.sv
// Blocking direct-mapped data cache, 16 lines of 16 bytes
// Word requests on the processor side, line transfers on the memory side

`include "cache_defs.svh"

module blocking_cache (
  input  logic                                     clk,
  input  logic                                     arst_n,

  // Processor side
  input  logic [$bits(mem_msg_pkg::cache_req_t)-1:0]  cachereq_msg,
  input  logic                                     cachereq_val,
  output logic                                     cachereq_rdy,
  output logic [$bits(mem_msg_pkg::cache_resp_t)-1:0] cacheresp_msg,
  output logic                                     cacheresp_val,
  input  logic                                     cacheresp_rdy,

  // Memory side
  output logic [$bits(mem_msg_pkg::mem_req_t)-1:0]    memreq_msg,
  output logic                                     memreq_val,
  input  logic                                     memreq_rdy,
  input  logic [$bits(mem_msg_pkg::mem_resp_t)-1:0]   memresp_msg,
  input  logic                                     memresp_val,
  output logic                                     memresp_rdy
);

  import mem_msg_pkg::*;

  // Flat port vectors viewed as message structs
  cache_req_t  cachereq;
  cache_resp_t cacheresp;
  mem_req_t    memreq;
  mem_resp_t   memresp;

  assign cachereq      = cachereq_msg;
  assign memresp       = memresp_msg;
  assign cacheresp_msg = cacheresp;
  assign memreq_msg    = memreq;

  // Tag and data arrays share one index
  line_store_if #(.entry_t(tag_entry_t)) tag_if ();
  line_store_if #(.entry_t(line_t))      data_if ();

  cache_ctrl u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (cachereq),
    .req_val   (cachereq_val),
    .req_rdy   (cachereq_rdy),
    .resp      (cacheresp),
    .resp_val  (cacheresp_val),
    .resp_rdy  (cacheresp_rdy),
    .mreq      (memreq),
    .mreq_val  (memreq_val),
    .mreq_rdy  (memreq_rdy),
    .mresp     (memresp),
    .mresp_val (memresp_val),
    .mresp_rdy (memresp_rdy),
    .tag_if    (tag_if.ctrl),
    .data_if   (data_if.ctrl)
  );

  line_store #(.entry_t(tag_entry_t), .NENTRIES(`CACHE_NLINES)) u_tag_store (
    .clk    (clk),
    .arst_n (arst_n),
    .port   (tag_if.store)
  );

  line_store #(.entry_t(line_t), .NENTRIES(`CACHE_NLINES)) u_data_store (
    .clk    (clk),
    .arst_n (arst_n),
    .port   (data_if.store)
  );

endmodule

// File: tb/tb_mem_model.sv
// Behavioral line memory for the cache testbench
// 4 KB of patterned bytes, random request stalls, 1 to 6 cycle answers

module tb_mem_model (
  input  logic                   clk,
  input  logic                   arst_n,
  input  mem_msg_pkg::mem_req_t  memreq_msg,
  input  logic                   memreq_val,
  output logic                   memreq_rdy,
  output mem_msg_pkg::mem_resp_t memresp_msg,
  output logic                   memresp_val,
  input  logic                   memresp_rdy,
  output int                     line_reads,
  output int                     word_writes,
  output int                     bad_msgs
);

  import mem_msg_pkg::*;

  logic [7:0] bytes [4096];

  // Every address bit feeds the fill value
  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return a[7:0] ^ (a[11:4] * 8'h1d) ^ 8'h96;
  endfunction

  // --------------------------------------------------------------------------
  // Request and response sequencing, all driven on the falling edge
  // --------------------------------------------------------------------------

  initial begin
    mem_req_t    req;
    mem_resp_t   rsp;
    logic [11:0] base;

    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp_msg = '0;
    line_reads  = 0;
    word_writes = 0;
    bad_msgs    = 0;
    for (int i = 0; i < 4096; i++) begin
      bytes[i] = fill_byte(12'(i));
    end
    forever begin
      @(negedge clk);
      // Stall about one cycle in four
      memreq_rdy = ($urandom_range(0, 3) != 0);
      if (arst_n && memreq_val && memreq_rdy) begin
        // Both high until the next rising edge, so this one transfers
        req  = memreq_msg;
        base = req.addr[11:0];
        @(negedge clk);
        memreq_rdy = 1'b0;
        rsp.type_  = req.type_;
        rsp.opaque = req.opaque;
        rsp.len    = req.len;
        rsp.data   = '0;
        if (req.type_ == MEM_READ) begin
          line_reads++;
          if (req.len != 4'd0 || base[3:0] != 4'd0) bad_msgs++;
          for (int i = 0; i < 16; i++) begin
            rsp.data[8*i +: 8] = bytes[base + i];
          end
        end else begin
          word_writes++;
          if (req.len != 4'd4 || base[1:0] != 2'd0) bad_msgs++;
          for (int i = 0; i < 4; i++) begin
            bytes[base + i] = req.data[8*i +: 8];
          end
        end
        // Extra wait of 0 to 5, response lands 1 to 6 cycles after accept
        repeat ($urandom_range(0, 5)) @(negedge clk);
        memresp_msg = rsp;
        memresp_val = 1'b1;
        while (!memresp_rdy) @(negedge clk);
        @(negedge clk);
        memresp_val = 1'b0;
      end
    end
  end

endmodule

// File: tb/tb_blocking_cache.sv
// Testbench for the blocking data cache
// Directed and random word accesses checked against a shadow memory

module tb_blocking_cache;

  import mem_msg_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int NUM_TESTS      = 5;
  localparam int CYCLES_PER_TEST = 2000;

  logic        clk;
  logic        arst_n;
  cache_req_t  cachereq_msg;
  logic        cachereq_val;
  logic        cachereq_rdy;
  cache_resp_t cacheresp_msg;
  logic        cacheresp_val;
  logic        cacheresp_rdy;
  mem_req_t    memreq_msg;
  logic        memreq_val;
  logic        memreq_rdy;
  mem_resp_t   memresp_msg;
  logic        memresp_val;
  logic        memresp_rdy;
  int          line_reads;
  int          word_writes;
  int          bad_msgs;

  // Shadow of memory contents, updated by every store issued
  logic [7:0]  shadow [4096];
  cache_resp_t exp_q [$];
  logic [7:0]  next_opq = 8'h00;
  bit          bp_on = 1'b0;
  int          cyc = 0;
  int          accept_cyc = 0;
  int          resp_cyc = 0;
  int          sent = 0;
  int          seen = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests_failed = 0;

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  blocking_cache u_dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .cachereq_msg  (cachereq_msg),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_msg (cacheresp_msg),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_msg    (memreq_msg),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_msg   (memresp_msg),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy)
  );

  tb_mem_model u_mem (
    .clk         (clk),
    .arst_n      (arst_n),
    .memreq_msg  (memreq_msg),
    .memreq_val  (memreq_val),
    .memreq_rdy  (memreq_rdy),
    .memresp_msg (memresp_msg),
    .memresp_val (memresp_val),
    .memresp_rdy (memresp_rdy),
    .line_reads  (line_reads),
    .word_writes (word_writes),
    .bad_msgs    (bad_msgs)
  );

  // --------------------------------------------------------------------------
  // Reference model and compare tasks
  // --------------------------------------------------------------------------

  // Same fill as the memory model's power-up contents
  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return a[7:0] ^ (a[11:4] * 8'h1d) ^ 8'h96;
  endfunction

  // Expected load word, little endian over shadow bytes
  function automatic logic [31:0] ref_load(input logic [11:0] a);
    return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
  endfunction

  task automatic check_resp(input cache_resp_t got, input cache_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t cacheresp_msg got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input int num, input string name, input int err_mark);
    if (errors == err_mark) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail (%0d errors)", num, name, errors - err_mark);
    end
  endtask

  // --------------------------------------------------------------------------
  // Request driver, blocks until the response has been checked
  // --------------------------------------------------------------------------

  task automatic issue(input mem_type_e kind, input logic [11:0] addr,
                       input logic [31:0] wdata);
    cache_resp_t exp;
    exp.type_  = kind;
    exp.opaque = next_opq;
    exp.len    = 2'd0;
    if (kind == MEM_WRITE) begin
      // Stores answer with zero data
      exp.data = '0;
      for (int i = 0; i < 4; i++) begin
        shadow[addr + i] = wdata[8*i +: 8];
      end
    end else begin
      exp.data = ref_load(addr);
    end
    exp_q.push_back(exp);
    @(negedge clk);
    cachereq_msg = '{type_: kind, opaque: next_opq, addr: {20'd0, addr},
                     len: 2'd0, data: wdata};
    cachereq_val = 1'b1;
    while (!cachereq_rdy) @(negedge clk);
    @(negedge clk);
    cachereq_val = 1'b0;
    accept_cyc   = cyc;
    next_opq++;
    sent++;
    while (seen < sent) @(negedge clk);
  endtask

  // Response side: back-pressure and compare
  initial begin
    cacheresp_rdy = 1'b1;
    forever begin
      @(negedge clk);
      cacheresp_rdy = bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;
      if (arst_n && cacheresp_val && cacheresp_rdy) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Cache answered at t=%0t with no request outstanding", $time);
        end else begin
          check_resp(cacheresp_msg, exp_q.pop_front());
        end
        resp_cyc = cyc;
        seen++;
      end
    end
  end

  // Watchdog sized from the test count
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the cache stopped answering",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    int          err_mark;
    int          rd_mark;
    int          wr_mark;
    int          stores;
    logic [11:0] a;

    void'($urandom(32'h7c99_a816));
    arst_n       = 1'b0;
    cachereq_val = 1'b0;
    cachereq_msg = '0;
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = fill_byte(12'(i));
    end
    repeat (8) @(negedge clk);
    arst_n = 1'b1;

    // 1: outputs idle after reset, cold read is one line read
    err_mark = errors;
    rd_mark  = line_reads;
    @(negedge clk);
    check_count("cacheresp_val", int'(cacheresp_val), 0);
    check_count("memreq_val", int'(memreq_val), 0);
    check_count("cachereq_rdy", int'(cachereq_rdy), 1);
    issue(MEM_READ, 12'h040, '0);
    check_count("line reads", line_reads - rd_mark, 1);
    report_test(1, "reset state and cold miss", err_mark);

    // 2: same line hits, answer one cycle after accept
    err_mark = errors;
    rd_mark  = line_reads;
    issue(MEM_READ, 12'h044, '0);
    check_count("hit latency", resp_cyc - accept_cyc + 1, 1);
    issue(MEM_READ, 12'h04c, '0);
    check_count("hit latency", resp_cyc - accept_cyc + 1, 1);
    check_count("line reads", line_reads - rd_mark, 0);
    report_test(2, "read hit", err_mark);

    // 3: write-through, cached line and uncached line
    err_mark = errors;
    rd_mark  = line_reads;
    wr_mark  = word_writes;
    issue(MEM_WRITE, 12'h048, 32'hcafe_0123);
    issue(MEM_READ, 12'h048, '0);
    issue(MEM_WRITE, 12'h300, 32'h1234_abcd);
    issue(MEM_READ, 12'h300, '0);
    check_count("word writes", word_writes - wr_mark, 2);
    check_count("line reads", line_reads - rd_mark, 1);
    report_test(3, "write-through", err_mark);

    // 4: index 8 conflict, every access refills
    err_mark = errors;
    rd_mark  = line_reads;
    for (int i = 0; i < 6; i++) begin
      issue(MEM_READ, (i % 2 == 1) ? 12'h184 : 12'h088, '0);
    end
    check_count("line reads", line_reads - rd_mark, 6);
    report_test(4, "index conflict", err_mark);

    // 5: random mix over 512 bytes with response stalls
    err_mark = errors;
    wr_mark  = word_writes;
    stores   = 0;
    bp_on    = 1'b1;
    for (int i = 0; i < 200; i++) begin
      a = 12'($urandom_range(0, 127) * 4);
      if ($urandom_range(0, 1) == 1) begin
        stores++;
        issue(MEM_WRITE, a, $urandom());
      end else begin
        issue(MEM_READ, a, '0);
      end
    end
    bp_on = 1'b0;
    check_count("responses", seen, sent);
    check_count("word writes", word_writes - wr_mark, stores);
    check_count("malformed memory requests", bad_msgs, 0);
    report_test(5, "random loads and stores", err_mark);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             NUM_TESTS, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+logic
logic/mem_msg_pkg.sv
logic/line_store_if.sv
logic/line_store.sv
logic/cache_ctrl.sv
logic/blocking_cache.sv
tb/tb_mem_model.sv
tb/tb_blocking_cache.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module tb_blocking_cache -f tb.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module tb_blocking_cache -f tb.f

clean:
	rm -rf obj_dir sim.log
